// ==== design/bht.sv ====
`default_nettype none

`include "btac_params.svh"

module bht import btac_pkg::*; (
  input logic clock,
  input logic reset,
  bht_if.tbl bus
);

  ctr_t counters [`BHT_DEPTH];

  // port 1 serves fetch, port 2 feeds the read-modify-write
  assign bus.rdata1 = counters[bus.raddr1];
  assign bus.rdata2 = counters[bus.raddr2];

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < `BHT_DEPTH; i++) begin
        counters[i] <= ctr_weak_nt; // weakly not taken
      end
    end else if (bus.wen) begin
      counters[bus.waddr] <= bus.wdata;
    end
  end

endmodule

`default_nettype wire

// ==== design/btac.sv ====
`default_nettype none

module btac import btac_pkg::*; (
  input logic clock,
  input logic reset,
  input logic clear,
  input addr_t get_pc,
  input logic upd_branch,
  input logic upd_jump,
  input addr_t upd_pc,
  input addr_t upd_addr,
  input addr_t upd_npc,
  input logic taken,
  input addr_t taddr,
  input addr_t tpc,
  output logic pred_branch,
  output addr_t pred_baddr,
  output addr_t pred_pc,
  output logic pred_miss,
  output addr_t pred_maddr
);

  btb_if btb_bus ();
  bht_if bht_bus ();

  btb u_btb (
    .clock (clock),
    .reset (reset),
    .bus   (btb_bus.tbl)
  );

  bht u_bht (
    .clock (clock),
    .reset (reset),
    .bus   (bht_bus.tbl)
  );

  btac_ctrl u_ctrl (
    .clock       (clock),
    .reset       (reset),
    .clear       (clear),
    .get_pc      (get_pc),
    .upd_branch  (upd_branch),
    .upd_jump    (upd_jump),
    .upd_pc      (upd_pc),
    .upd_addr    (upd_addr),
    .upd_npc     (upd_npc),
    .taken       (taken),
    .taddr       (taddr),
    .tpc         (tpc),
    .pred_branch (pred_branch),
    .pred_baddr  (pred_baddr),
    .pred_pc     (pred_pc),
    .pred_miss   (pred_miss),
    .pred_maddr  (pred_maddr),
    .btb         (btb_bus.ctrl),
    .bht         (bht_bus.ctrl)
  );

endmodule

`default_nettype wire

// ==== design/btac_ctrl.sv ====
`default_nettype none

module btac_ctrl import btac_pkg::*; (
  input logic clock,
  input logic reset,
  input logic clear,
  input addr_t get_pc,
  input logic upd_branch,
  input logic upd_jump,
  input addr_t upd_pc,
  input addr_t upd_addr,
  input addr_t upd_npc,
  input logic taken,
  input addr_t taddr,
  input addr_t tpc,
  output logic pred_branch,
  output addr_t pred_baddr,
  output addr_t pred_pc,
  output logic pred_miss,
  output addr_t pred_maddr,
  btb_if.ctrl btb,
  bht_if.ctrl bht
);

  btb_idx_t fetch_btb_idx;
  btb_idx_t upd_btb_idx;
  bht_idx_t fetch_bht_idx;
  bht_idx_t upd_bht_idx;
  addr_t entry_pc;
  addr_t entry_target;
  addr_t entry_npc;
  logic hit;
  logic upd_en;
  ctr_t ctr_next;

  //////////////////////////////
  // indexing
  //////////////////////////////

  // bit 0 is never set in a code address, so the index starts at bit 1
  assign fetch_btb_idx = get_pc[btb_idx_w:1];
  assign upd_btb_idx = upd_pc[btb_idx_w:1];
  assign fetch_bht_idx = get_pc[bht_idx_w:1];
  assign upd_bht_idx = upd_pc[bht_idx_w:1];

  assign btb.raddr = fetch_btb_idx;
  assign bht.raddr1 = fetch_bht_idx;
  assign bht.raddr2 = upd_bht_idx;

  //////////////////////////////
  // prediction
  //////////////////////////////

  assign {entry_pc, entry_target, entry_npc} = btb.rdata;
  assign hit = btb.rvalid && (entry_pc == get_pc); // full tag compare

  always_comb begin
    pred_branch = 1'b0;
    pred_baddr = '0;
    pred_pc = '0;
    if (!clear && hit) begin
      pred_branch = bht.rdata1[1]; // counter decides, the entry only supplies targets
      pred_baddr = entry_target;
      pred_pc = entry_npc;
    end
  end

  //////////////////////////////
  // update
  //////////////////////////////

  assign upd_en = reset && !clear && upd_branch; // tables stay idle during reset

  always_comb begin
    ctr_next = bht.rdata2;
    if (upd_jump) begin
      if (bht.rdata2 != ctr_max) begin
        ctr_next = bht.rdata2 + 2'd1;
      end
    end else if (bht.rdata2 != ctr_min) begin
      ctr_next = bht.rdata2 - 2'd1;
    end
  end

  assign bht.wen = upd_en; // every resolved branch trains its counter
  assign bht.waddr = upd_bht_idx;
  assign bht.wdata = ctr_next;

  // only taken transfers allocate a target entry
  assign btb.wen = upd_en && upd_jump;
  assign btb.waddr = upd_btb_idx;
  assign btb.wdata = {upd_pc, upd_addr, upd_npc};

  //////////////////////////////
  // misprediction check
  //////////////////////////////

  always_comb begin
    pred_miss = 1'b0;
    pred_maddr = '0;
    if (!clear && upd_branch) begin
      unique case ({taken, upd_jump})
        2'b01: begin
          pred_miss = 1'b1; // fetch fell through but the branch went
          pred_maddr = upd_addr;
        end
        2'b10: begin
          pred_miss = 1'b1; // fetch jumped but the branch fell through
          pred_maddr = tpc;
        end
        2'b11: begin
          if (upd_addr != taddr) begin
            pred_miss = 1'b1; // right direction, stale target
            pred_maddr = upd_addr;
          end
        end
        default: begin
        end
      endcase
    end
  end

  a_miss_only_on_resolve: assert property (
    @(posedge clock) disable iff (!reset) pred_miss |-> upd_branch
  );

  // a flush must leave both tables untouched
  a_no_write_on_clear: assert property (
    @(posedge clock) disable iff (!reset) clear |-> !(btb.wen || bht.wen)
  );

endmodule

`default_nettype wire

// ==== design/btac_ifs.sv ====
`default_nettype none

//////////////////////////////
// controller to target buffer
//////////////////////////////

interface btb_if import btac_pkg::*; ();
  logic wen;
  btb_idx_t waddr;
  btb_entry_t wdata;
  btb_idx_t raddr;
  btb_entry_t rdata; // combinational from raddr
  logic rvalid;

  modport ctrl (output wen, waddr, wdata, raddr, input rdata, rvalid);
  modport tbl (input wen, waddr, wdata, raddr, output rdata, rvalid);
endinterface

//////////////////////////////
// controller to history table
//////////////////////////////

interface bht_if import btac_pkg::*; ();
  logic wen;
  bht_idx_t waddr;
  ctr_t wdata;
  bht_idx_t raddr1; // fetch lookup
  bht_idx_t raddr2; // update address, read before the write back
  ctr_t rdata1;
  ctr_t rdata2;

  modport ctrl (output wen, waddr, wdata, raddr1, raddr2, input rdata1, rdata2);
  modport tbl (input wen, waddr, wdata, raddr1, raddr2, output rdata1, rdata2);
endinterface

`default_nettype wire

// ==== design/btac_params.svh ====
`ifndef BTAC_PARAMS_SVH
`define BTAC_PARAMS_SVH

// width of a code address
`define ADDR_W 32

// number of entries in the direct-mapped target buffer
`define BTB_DEPTH 64

// number of 2-bit counters in the history table
`define BHT_DEPTH 256

`endif

// ==== design/btac_pkg.sv ====
`default_nettype none

`include "btac_params.svh"

package btac_pkg;

  localparam int btb_idx_w = $clog2(`BTB_DEPTH);
  localparam int bht_idx_w = $clog2(`BHT_DEPTH);

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [btb_idx_w-1:0] btb_idx_t;
  typedef logic [bht_idx_w-1:0] bht_idx_t;

  // msb set means predict taken
  typedef logic [1:0] ctr_t;

  localparam ctr_t ctr_min = 2'd0;
  localparam ctr_t ctr_weak_nt = 2'd1; // value every counter takes at reset
  localparam ctr_t ctr_max = 2'd3;

  // branch pc on top, then target, then next pc
  typedef logic [3*`ADDR_W-1:0] btb_entry_t;

endpackage

`default_nettype wire

// ==== design/btb.sv ====
`default_nettype none

`include "btac_params.svh"

module btb import btac_pkg::*; (
  input logic clock,
  input logic reset,
  btb_if.tbl bus
);

  btb_entry_t entries [`BTB_DEPTH];
  logic [`BTB_DEPTH-1:0] valid;

  // reads see the old contents in the cycle of a write
  assign bus.rdata = entries[bus.raddr];
  assign bus.rvalid = valid[bus.raddr];

  always_ff @(posedge clock) begin
    if (bus.wen) begin
      entries[bus.waddr] <= bus.wdata;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid <= '0; // every entry starts empty
    end else if (bus.wen) begin
      valid[bus.waddr] <= 1'b1;
    end
  end

  // a write to an unknown slot would corrupt an arbitrary entry
  a_waddr_known: assert property (
    @(posedge clock) disable iff (!reset) bus.wen |-> !$isunknown(bus.waddr)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module btac_tb -f tb.f -o Vbtac_tb
./obj_dir/Vbtac_tb | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

// ==== sim/btac_tb.sv ====
`default_nettype none

`include "btac_params.svh"

module btac_tb import btac_pkg::*; ();

  localparam int max_cycles = 3000; // about 40 directed cycles and 2000 random ones, with margin

  typedef struct packed {
    logic branch;
    addr_t baddr;
    addr_t npc;
    logic miss;
    addr_t maddr;
  } expect_t;

  logic clock;
  logic reset;
  logic clear;
  addr_t get_pc;
  logic upd_branch;
  logic upd_jump;
  addr_t upd_pc;
  addr_t upd_addr;
  addr_t upd_npc;
  logic taken;
  addr_t taddr;
  addr_t tpc;
  logic pred_branch;
  addr_t pred_baddr;
  addr_t pred_pc;
  logic pred_miss;
  addr_t pred_maddr;

  logic model_valid [`BTB_DEPTH];
  addr_t model_pc [`BTB_DEPTH];
  addr_t model_target [`BTB_DEPTH];
  addr_t model_npc [`BTB_DEPTH];
  ctr_t model_ctr [`BHT_DEPTH];

  int errors = 0;
  int checks = 0;
  int cycles = 0;
  logic [31:0] rand_state = 32'hb6a6;

  btac u_btac (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // bit 7 aliases in the BTB only, bit 9 aliases in both tables
  function automatic addr_t window_pc(input logic [3:0] k);
    return 32'h0000_1000 | {22'b0, k[3], 1'b0, k[2], 3'b0, k[1:0], 2'b00};
  endfunction

  function automatic expect_t predict_outputs();
    expect_t e;
    btb_idx_t bi;
    bht_idx_t hi;
    e = '0;
    bi = get_pc[btb_idx_w:1];
    hi = get_pc[bht_idx_w:1];
    if (!clear && model_valid[bi] && model_pc[bi] == get_pc) begin
      e.branch = model_ctr[hi][1]; // counter msb gates the hit
      e.baddr = model_target[bi];
      e.npc = model_npc[bi];
    end
    if (!clear && upd_branch) begin
      if (!taken && upd_jump) begin
        e.miss = 1'b1;
        e.maddr = upd_addr;
      end else if (taken && !upd_jump) begin
        e.miss = 1'b1;
        e.maddr = tpc;
      end else if (taken && upd_jump && upd_addr != taddr) begin
        e.miss = 1'b1;
        e.maddr = upd_addr;
      end
    end
    return e;
  endfunction

  task automatic reset_model();
    for (int i = 0; i < `BTB_DEPTH; i++) begin
      model_valid[i] = 1'b0;
    end
    for (int i = 0; i < `BHT_DEPTH; i++) begin
      model_ctr[i] = 2'd1;
    end
  endtask

  task automatic apply_update();
    btb_idx_t bi;
    bht_idx_t hi;
    bi = upd_pc[btb_idx_w:1];
    hi = upd_pc[bht_idx_w:1];
    if (!clear && upd_branch) begin
      if (upd_jump && model_ctr[hi] != 2'd3) begin
        model_ctr[hi] = model_ctr[hi] + 2'd1;
      end else if (!upd_jump && model_ctr[hi] != 2'd0) begin
        model_ctr[hi] = model_ctr[hi] - 2'd1;
      end
      if (upd_jump) begin
        model_valid[bi] = 1'b1;
        model_pc[bi] = upd_pc;
        model_target[bi] = upd_addr;
        model_npc[bi] = upd_npc;
      end
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    checks++;
    assert (expected === actual) else begin
      errors++;
      $display("FAIL %s: expected %h, actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
    checks++;
    assert (expected === actual) else begin
      errors++;
      $display("FAIL %s: expected %h, actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  // outputs are stable one time unit after the falling edge
  initial begin
    expect_t e;
    forever begin
      @(negedge clock);
      #1;
      if (!reset) begin
        reset_model();
      end else begin
        e = predict_outputs();
        check_bit("pred_branch", e.branch, pred_branch);
        check_addr("pred_baddr", e.baddr, pred_baddr);
        check_addr("pred_pc", e.npc, pred_pc);
        check_bit("pred_miss", e.miss, pred_miss);
        check_addr("pred_maddr", e.maddr, pred_maddr);
        apply_update();
      end
    end
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("errors: %0d of %0d checks", errors, checks);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  task automatic drive_inputs(input addr_t pc, input logic ub, input logic uj, input addr_t upc,
                              input addr_t uaddr, input logic tk, input addr_t ta,
                              input logic clr);
    @(negedge clock);
    get_pc = pc;
    upd_branch = ub;
    upd_jump = uj;
    upd_pc = upc;
    upd_addr = uaddr;
    upd_npc = upc + 32'd4;
    taken = tk;
    taddr = ta;
    tpc = upc + 32'd4; // fetch fall-through of the resolved branch
    clear = clr;
  endtask

  // hand-worked values from the prediction and miss rules
  task automatic expect_now(input logic br, input addr_t baddr, input addr_t npc,
                            input logic miss, input addr_t maddr);
    #1;
    check_bit("pred_branch", br, pred_branch);
    check_addr("pred_baddr", baddr, pred_baddr);
    check_addr("pred_pc", npc, pred_pc);
    check_bit("pred_miss", miss, pred_miss);
    check_addr("pred_maddr", maddr, pred_maddr);
  endtask

  initial begin
    logic [31:0] r;
    addr_t pa;
    addr_t pb;
    addr_t t1;
    addr_t t2;
    pa = 32'h0000_1010;
    pb = 32'h0000_1200;
    t1 = 32'h0000_4000;
    t2 = 32'h0000_4800;
    reset = 1'b0;
    clear = 1'b0;
    get_pc = '0;
    upd_branch = 1'b0;
    upd_jump = 1'b0;
    upd_pc = '0;
    upd_addr = '0;
    upd_npc = '0;
    taken = 1'b0;
    taddr = '0;
    tpc = '0;
    repeat (5) @(negedge clock);
    reset = 1'b1;

    for (int k = 0; k < 16; k++) begin
      drive_inputs(window_pc(k[3:0]), 1'b0, 1'b0, '0, '0, 1'b0, '0, 1'b0);
      expect_now(1'b0, '0, '0, 1'b0, '0); // nothing valid yet
    end

    drive_inputs(pa, 1'b1, 1'b1, pa, t1, 1'b0, '0, 1'b0);
    expect_now(1'b0, '0, '0, 1'b1, t1); // same-cycle lookup still misses
    drive_inputs(pa, 1'b0, 1'b0, '0, '0, 1'b0, '0, 1'b0);
    expect_now(1'b1, t1, pa + 32'd4, 1'b0, '0);

    drive_inputs(pa, 1'b1, 1'b0, pa, t1, 1'b1, t1, 1'b0);
    expect_now(1'b1, t1, pa + 32'd4, 1'b1, pa + 32'd4);
    drive_inputs(pa, 1'b1, 1'b1, pa, t1, 1'b1, t1, 1'b0);
    expect_now(1'b0, t1, pa + 32'd4, 1'b0, '0); // entry matches, counter at 1
    drive_inputs(pa, 1'b1, 1'b1, pa, t1, 1'b1, t1, 1'b0);
    expect_now(1'b1, t1, pa + 32'd4, 1'b0, '0);
    drive_inputs(pa, 1'b1, 1'b1, pa, t1, 1'b1, t1, 1'b0);
    expect_now(1'b1, t1, pa + 32'd4, 1'b0, '0);
    drive_inputs(pa, 1'b1, 1'b0, pa, t1, 1'b0, '0, 1'b0);
    expect_now(1'b1, t1, pa + 32'd4, 1'b0, '0);
    drive_inputs(pa, 1'b0, 1'b0, '0, '0, 1'b0, '0, 1'b0);
    expect_now(1'b1, t1, pa + 32'd4, 1'b0, '0); // counter saturated at 3, now 2

    drive_inputs(pa, 1'b1, 1'b1, pa, t2, 1'b1, t1, 1'b0);
    expect_now(1'b1, t1, pa + 32'd4, 1'b1, t2); // right direction, new target

    drive_inputs(pa, 1'b1, 1'b0, pa, t2, 1'b1, t2, 1'b1);
    expect_now(1'b0, '0, '0, 1'b0, '0);
    drive_inputs(pb, 1'b1, 1'b1, pb, t1, 1'b0, '0, 1'b1);
    expect_now(1'b0, '0, '0, 1'b0, '0);
    drive_inputs(pa, 1'b1, 1'b0, pa, t2, 1'b0, '0, 1'b0);
    expect_now(1'b1, t2, pa + 32'd4, 1'b0, '0); // counter at 3 steps down to 2
    drive_inputs(pb, 1'b0, 1'b0, '0, '0, 1'b0, '0, 1'b0);
    expect_now(1'b0, '0, '0, 1'b0, '0);
    drive_inputs(pa, 1'b0, 1'b0, '0, '0, 1'b0, '0, 1'b0);
    expect_now(1'b1, t2, pa + 32'd4, 1'b0, '0); // would be 1 had the flushed update counted

    for (int n = 0; n < 2000; n++) begin
      rand_state = xorshift(rand_state);
      r = rand_state;
      drive_inputs(window_pc(r[3:0]), r[4] | r[5], r[6], window_pc(r[10:7]),
                   32'h0000_8000 + {28'b0, r[12:11], 2'b00}, r[13],
                   32'h0000_8000 + {28'b0, r[15:14], 2'b00}, r[20:16] == 5'd0);
    end

    repeat (2) @(negedge clock);
    $display("errors: %0d of %0d checks", errors, checks);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+design
design/btac_pkg.sv
design/btac_ifs.sv
design/btb.sv
design/bht.sv
design/btac_ctrl.sv
design/btac.sv
sim/btac_tb.sv
